// File: project.f
crc_cfg_pkg.sv
crc_types_pkg.sv
credit_fifo.sv
frame_dispatcher.sv
crc5_serial_engine.sv
result_collector.sv
crc5_multi_top.sv
tb_crc5_multi.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_crc5_multi
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "All tests passed" $(LOG); then \
		echo "Simulation result: pass"; \
	else \
		echo "Simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_crc5_multi.sv
// ------------------------------
// Multi-engine CRC-5 testbench
// Random frames under credit flow control,
// checked against a bitwise CRC model
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_crc5_multi;

  localparam int CLK_PERIOD   = 8;
  localparam int DRIVE_DELAY  = 1;                        // After each rising edge
  localparam int RAND_FRAMES  = 300;
  localparam int EDGE_FRAMES  = 2;                        // Single 00 byte, then 255 x FF
  localparam int TOTAL_FRAMES = RAND_FRAMES + EDGE_FRAMES;
  localparam int IN_DEPTH     = crc_cfg_pkg::IN_DEPTH;
  localparam int RES_WINDOW   = 4;                        // Downstream slots held at most
  // Longest frame at 10 cycles per byte
  localparam int TIMEOUT_NS   = TOTAL_FRAMES * 256 * 10 * CLK_PERIOD;

  logic                       i_sys_clk;
  logic                       i_sys_rst;
  logic                       i_beat_valid;
  crc_types_pkg::beat_t       i_beat;
  logic                       o_beat_credit;
  logic                       i_res_credit;
  logic                       o_res_valid;
  crc_types_pkg::crc_result_t o_res;

  logic [15:0] lfsr_state = 16'd3;   // Seed
  int          error_count;
  int          check_count;
  int          up_credit;            // Upstream's credit counter
  int          beats_sent;
  int          credits_returned;
  int          frames_started;
  int          frame_kind;           // 0 zero byte, 1 all FF, 2 random
  int          frame_len;
  int          bytes_left;
  logic [4:0]  crc_model;            // Running CRC of the frame being sent
  int          res_granted;
  int          res_seen;
  int          stall_cycles;
  crc_types_pkg::crc_result_t expected_q[$];

  crc5_multi_top DUT (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst     (i_sys_rst),
    .i_beat_valid  (i_beat_valid),
    .i_beat        (i_beat),
    .o_beat_credit (o_beat_credit),
    .i_res_credit  (i_res_credit),
    .o_res_valid   (o_res_valid),
    .o_res         (o_res)
  );

  initial begin
    i_sys_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_sys_clk = ~i_sys_clk;
  end

  // Galois LFSR, taps 0xB400, one step per bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] value;
    logic        lsb;
    value = '0;
    for (int i = 0; i < n; i++) begin
      lsb        = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) begin
        lfsr_state = lfsr_state ^ 16'hB400;
      end
      value = {value[14:0], lsb};
    end
    return value;
  endfunction

  // x^5 + x^2 + 1, MSB first, feedback = top bit XOR data bit
  function automatic logic [4:0] crc_of_byte(input logic [4:0] crc_in, input logic [7:0] data);
    logic [4:0] crc;
    logic       feedback;
    crc = crc_in;
    for (int i = 7; i >= 0; i--) begin
      feedback = crc[4] ^ data[i];
      crc      = {crc[3:0], 1'b0};
      if (feedback) begin
        crc = crc ^ 5'b00101;
      end
    end
    return crc;
  endfunction

  task automatic check_result(input crc_types_pkg::crc_result_t got,
                              input crc_types_pkg::crc_result_t exp_res);
    check_count++;
    if (got.crc !== exp_res.crc) begin
      error_count++;
      $display("CHECK FAILED o_res.crc got 0x%0h expected 0x%0h", got.crc, exp_res.crc);
    end
    if (got.len !== exp_res.len) begin
      error_count++;
      $display("CHECK FAILED o_res.len got 0x%0h expected 0x%0h", got.len, exp_res.len);
    end
  endtask

  task automatic check_credit(input string name, input int got, input int exp_cnt);
    check_count++;
    if (got != exp_cnt) begin
      error_count++;
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp_cnt);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp_bit);
    check_count++;
    if (got !== exp_bit) begin
      error_count++;
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp_bit);
    end
  endtask

  task automatic flag_failure(input string what);
    error_count++;
    $display("ERROR at %0t ns: %s", $time, what);
  endtask

  // Credit returns and results seen at this edge
  task automatic sample_outputs();
    crc_types_pkg::crc_result_t exp_res;
    if (o_beat_credit === 1'b1) begin
      up_credit++;
      credits_returned++;
    end
    if (up_credit < 0 || up_credit > IN_DEPTH) begin
      flag_failure("upstream credit count left the range 0 to the input buffer depth");
    end
    if (o_res_valid === 1'b1) begin
      res_seen++;
      if (res_seen > res_granted) begin
        flag_failure("more results emitted than downstream credits granted");
      end
      if (expected_q.size() == 0) begin
        flag_failure("result emitted with no frame outstanding");
      end else begin
        exp_res = expected_q.pop_front();
        check_result(o_res, exp_res);
      end
    end
  endtask

  task automatic start_frame();
    if (frames_started == 0) begin
      frame_kind = 0;
      frame_len  = 1;
    end else if (frames_started == 1) begin
      frame_kind = 1;
      frame_len  = 255;
    end else begin
      frame_kind = 2;
      if (rand_bits(1) == 16'd1) begin
        frame_len = int'(rand_bits(4)) + 1;   // Short frames rotate engines fast
      end else begin
        frame_len = int'(rand_bits(8));
        if (frame_len == 0) begin
          frame_len = 1;
        end
      end
    end
    bytes_left = frame_len;
    crc_model  = 5'b11111;   // Preset per frame
    frames_started++;
  endtask

  task automatic drive_upstream();
    crc_types_pkg::beat_t       beat;
    crc_types_pkg::crc_result_t res;
    i_beat_valid = 1'b0;
    if (bytes_left == 0 && frames_started < TOTAL_FRAMES) begin
      start_frame();
    end
    // Send only on credit, with random gaps
    if (bytes_left > 0 && up_credit > 0 && rand_bits(2) != 16'd0) begin
      if (frame_kind == 0) begin
        beat.data = 8'h00;
      end else if (frame_kind == 1) begin
        beat.data = 8'hFF;
      end else begin
        beat.data = 8'(rand_bits(8));
      end
      bytes_left--;
      beat.last    = (bytes_left == 0);
      crc_model    = crc_of_byte(crc_model, beat.data);
      i_beat       = beat;
      i_beat_valid = 1'b1;
      up_credit--;
      beats_sent++;
      if (beat.last) begin
        res.crc = crc_model;
        res.len = 8'(frame_len);
        expected_q.push_back(res);
      end
    end
  endtask

  // Grants inside a small window, broken by long stalls
  task automatic drive_downstream();
    i_res_credit = 1'b0;
    if (res_granted < TOTAL_FRAMES) begin
      if (stall_cycles > 0) begin
        stall_cycles--;
      end else if (rand_bits(6) == 16'd0) begin
        stall_cycles = 100 + int'(rand_bits(8));   // Engines back up behind this
      end else if (res_granted - res_seen < RES_WINDOW && rand_bits(1) == 16'd1) begin
        i_res_credit = 1'b1;
        res_granted++;
      end
    end
  endtask

  task automatic run_cycle();
    @(posedge i_sys_clk);
    #(DRIVE_DELAY);
    sample_outputs();
    drive_upstream();
    drive_downstream();
  endtask

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns with %0d of %0d results, checks %0d, errors %0d",
             TIMEOUT_NS, res_seen, TOTAL_FRAMES, check_count, error_count);
    $display("Some tests failed");
    $finish;
  end

  initial begin : stimulus
    crc_types_pkg::crc_result_t hand_res;
    i_sys_rst        = 1'b0;
    i_beat_valid     = 1'b0;
    i_beat           = '0;
    i_res_credit     = 1'b0;
    error_count      = 0;
    check_count      = 0;
    up_credit        = IN_DEPTH;
    beats_sent       = 0;
    credits_returned = 0;
    frames_started   = 0;
    frame_kind       = 0;
    frame_len        = 0;
    bytes_left       = 0;
    crc_model        = 5'b11111;
    res_granted      = 0;
    res_seen         = 0;
    stall_cycles     = 0;

    // Byte 00 from preset 11111 worked by hand gives 01111
    hand_res.crc = crc_of_byte(5'b11111, 8'h00);
    hand_res.len = 8'd1;
    check_result(hand_res, '{crc: 5'h0F, len: 8'd1});

    repeat (2) @(posedge i_sys_clk);
    #(DRIVE_DELAY);
    i_sys_rst = 1'b1;

    repeat (8) begin   // Nothing moves before beats or credits
      @(posedge i_sys_clk);
      #(DRIVE_DELAY);
      check_flag("o_res_valid", o_res_valid, 1'b0);
      check_flag("o_beat_credit", o_beat_credit, 1'b0);
    end

    while (res_seen < TOTAL_FRAMES) begin
      run_cycle();
    end
    repeat (20) begin  // Catch stray results and late credit pulses
      run_cycle();
    end

    check_credit("beat credits returned", credits_returned, beats_sent);
    check_credit("upstream credit count", up_credit, IN_DEPTH);
    check_credit("results received", res_seen, TOTAL_FRAMES);
    check_credit("results still expected", expected_q.size(), 0);

    $display("Frames %0d, beats %0d, checks %0d, errors %0d",
             TOTAL_FRAMES, beats_sent, check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: crc5_multi_top.sv
// ------------------------------
// Multi-engine CRC-5 top
// Dispatcher, engine array and collector
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module crc5_multi_top (
  input  wire                          i_sys_clk,
  input  wire                          i_sys_rst,
  input  wire                          i_beat_valid,
  input  wire crc_types_pkg::beat_t    i_beat,
  output logic                         o_beat_credit,
  input  wire                          i_res_credit,
  output logic                         o_res_valid,
  output crc_types_pkg::crc_result_t   o_res
);

  localparam int N = crc_cfg_pkg::NUM_ENGINES;

  wire [N-1:0]                         eng_valid;    // Byte strobe per engine
  wire [N-1:0]                         eng_credit;   // Byte slot returned
  wire [N-1:0]                         res_valid;
  wire [N-1:0]                         res_pop;
  wire crc_types_pkg::beat_t           eng_beat;     // Shared beat bus
  wire crc_types_pkg::crc_result_t [N-1:0] eng_res;

  frame_dispatcher u_dispatch (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst     (i_sys_rst),
    .i_beat_valid  (i_beat_valid),
    .i_beat        (i_beat),
    .o_beat_credit (o_beat_credit),
    .o_eng_valid   (eng_valid),
    .o_eng_beat    (eng_beat),
    .i_eng_credit  (eng_credit)
  );

  for (genvar k = 0; k < N; k++) begin : g_eng
    crc5_serial_engine u_engine (
      .i_sys_clk   (i_sys_clk),
      .i_sys_rst   (i_sys_rst),
      .i_valid     (eng_valid[k]),
      .i_beat      (eng_beat),
      .o_credit    (eng_credit[k]),
      .o_res_valid (res_valid[k]),
      .o_res       (eng_res[k]),
      .i_res_pop   (res_pop[k])
    );
  end

  result_collector u_collect (
    .i_sys_clk    (i_sys_clk),
    .i_sys_rst    (i_sys_rst),
    .i_eng_valid  (res_valid),
    .i_eng_res    (eng_res),
    .o_eng_pop    (res_pop),
    .i_res_credit (i_res_credit),
    .o_res_valid  (o_res_valid),
    .o_res        (o_res)
  );

endmodule

`default_nettype wire

// File: result_collector.sv
// ------------------------------
// Result collector
// In-order round-robin drain under
// downstream credits
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module result_collector (
  input  wire                                                       i_sys_clk,
  input  wire                                                       i_sys_rst,
  input  wire [crc_cfg_pkg::NUM_ENGINES-1:0]                        i_eng_valid,
  input  wire crc_types_pkg::crc_result_t [crc_cfg_pkg::NUM_ENGINES-1:0] i_eng_res,
  output logic [crc_cfg_pkg::NUM_ENGINES-1:0]                       o_eng_pop,
  input  wire                                                       i_res_credit,
  output logic                                                      o_res_valid,
  output crc_types_pkg::crc_result_t                                o_res
);

  localparam int N  = crc_cfg_pkg::NUM_ENGINES;
  localparam int SW = crc_cfg_pkg::ENG_SEL_WIDTH;
  localparam int RW = crc_cfg_pkg::RES_CREDIT_WIDTH;

  logic [SW-1:0] ptr;      // Engine holding the oldest frame
  logic [RW-1:0] credit;   // Downstream slots available
  logic          take;

  assign take = i_eng_valid[ptr] && (credit != '0);

  always_comb begin
    o_eng_pop      = '0;
    o_eng_pop[ptr] = take;
  end

  always_ff @(posedge i_sys_clk) begin
    if (take) begin
      o_res <= i_eng_res[ptr];
    end
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      ptr         <= '0;
      credit      <= '0;   // Downstream grants first
      o_res_valid <= 1'b0;
    end else begin
      o_res_valid <= take;
      if (take) begin
        ptr <= (ptr == SW'(N - 1)) ? '0 : ptr + 1'b1;   // Same order as dispatch
      end
      if (i_res_credit && !take) begin
        credit <= credit + 1'b1;
      end else if (!i_res_credit && take) begin
        credit <= credit - 1'b1;
      end
    end
  end

  // Every emitted result was backed by a grant one cycle earlier
  a_spend_with_credit: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    o_res_valid |-> ($past(credit) != '0))
    else $error("result_collector: result sent without credit");

  a_credit_no_wrap: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    (i_res_credit && !take) |-> (credit != '1))
    else $error("result_collector: credit counter overflow");

endmodule

`default_nettype wire

// File: crc5_serial_engine.sv
// ------------------------------
// Bit-serial CRC-5 engine
// One frame at a time, one bit per clock,
// result parked in a one-entry buffer
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module crc5_serial_engine (
  input  wire                          i_sys_clk,
  input  wire                          i_sys_rst,
  input  wire                          i_valid,
  input  wire crc_types_pkg::beat_t    i_beat,
  output logic                         o_credit,
  output logic                         o_res_valid,
  output crc_types_pkg::crc_result_t   o_res,
  input  wire                          i_res_pop
);

  localparam int CW = crc_cfg_pkg::CRC_WIDTH;
  localparam int LW = crc_cfg_pkg::LEN_WIDTH;

  typedef enum logic [1:0] {
    ST_IDLE,     // Waiting for a byte
    ST_SHIFT,    // Walking 8 bits
    ST_WRITE     // Frame done, result pending
  } state_t;

  state_t                     state;
  crc_types_pkg::beat_t       byte_head;
  crc_types_pkg::crc_result_t res_in;
  logic                       byte_empty;
  logic                       res_empty;
  logic                       res_full;
  logic                       pop_byte;
  logic                       push_res;
  logic [7:0]                 data_reg;    // Byte in flight, next bit at the top
  logic                       byte_last;
  logic [2:0]                 bit_cnt;
  logic [CW-1:0]              crc_q;
  logic [CW-1:0]              crc_step;
  logic [LW-1:0]              len_q;       // Bytes taken in this frame
  logic                       fb;

  credit_fifo #(
    .payload_t (crc_types_pkg::beat_t),
    .DEPTH     (crc_cfg_pkg::ENG_BYTE_DEPTH)
  ) u_byte_fifo (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst   (i_sys_rst),
    .i_push      (i_valid),
    .i_push_data (i_beat),
    .i_pop       (pop_byte),
    .o_pop_data  (byte_head),
    .o_empty     (byte_empty),
    .o_full      ()
  );

  credit_fifo #(
    .payload_t (crc_types_pkg::crc_result_t),
    .DEPTH     (1)
  ) u_res_fifo (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst   (i_sys_rst),
    .i_push      (push_res),
    .i_push_data (res_in),
    .i_pop       (i_res_pop),
    .o_pop_data  (o_res),
    .o_empty     (res_empty),
    .o_full      (res_full)
  );

  assign pop_byte    = (state == ST_IDLE) && !byte_empty;
  assign push_res    = (state == ST_WRITE) && !res_full;  // Stall here while full
  assign o_credit    = pop_byte;                         // One credit per byte slot freed
  assign o_res_valid = !res_empty;

  // Feedback is top bit XOR data bit, poly folded in on a one
  assign fb       = crc_q[CW-1] ^ data_reg[7];
  assign crc_step = {crc_q[CW-2:0], 1'b0} ^ (fb ? crc_cfg_pkg::CRC_POLY : '0);
  assign res_in   = '{crc: crc_q, len: len_q};

  always_ff @(posedge i_sys_clk) begin
    if (pop_byte) begin
      data_reg  <= byte_head.data;
      byte_last <= byte_head.last;
    end else if (state == ST_SHIFT) begin
      data_reg  <= {data_reg[6:0], 1'b0};   // MSB first
    end
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      state   <= ST_IDLE;
      bit_cnt <= '0;
      crc_q   <= crc_cfg_pkg::CRC_INIT;
      len_q   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (pop_byte) begin
            len_q <= len_q + 1'b1;
            state <= ST_SHIFT;
          end
        end
        ST_SHIFT: begin
          crc_q   <= crc_step;
          bit_cnt <= bit_cnt + 1'b1;   // Wraps to 0 after bit 7
          if (bit_cnt == 3'd7) begin
            state <= byte_last ? ST_WRITE : ST_IDLE;
          end
        end
        ST_WRITE: begin
          if (push_res) begin
            crc_q <= crc_cfg_pkg::CRC_INIT;   // Preset for the next frame
            len_q <= '0;
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: frame_dispatcher.sv
// ------------------------------
// Frame dispatcher
// Buffers upstream beats, returns credits and
// steers whole frames round robin to the engines
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module frame_dispatcher (
  input  wire                                      i_sys_clk,
  input  wire                                      i_sys_rst,
  input  wire                                      i_beat_valid,
  input  wire crc_types_pkg::beat_t                i_beat,
  output logic                                     o_beat_credit,
  output logic [crc_cfg_pkg::NUM_ENGINES-1:0]      o_eng_valid,
  output crc_types_pkg::beat_t                     o_eng_beat,
  input  wire  [crc_cfg_pkg::NUM_ENGINES-1:0]      i_eng_credit
);

  localparam int N   = crc_cfg_pkg::NUM_ENGINES;
  localparam int SW  = crc_cfg_pkg::ENG_SEL_WIDTH;
  localparam int CW  = crc_cfg_pkg::ENG_CNT_WIDTH;

  crc_types_pkg::beat_t head;         // Oldest buffered beat
  logic                 in_empty;
  logic                 fwd;          // Head leaves this cycle
  logic [SW-1:0]        target;       // Engine owning the current frame
  logic [CW-1:0]        eng_cnt [N];  // Free byte slots per engine

  // Upstream never sends without credit, so the full flag stays unused
  credit_fifo #(
    .payload_t (crc_types_pkg::beat_t),
    .DEPTH     (crc_cfg_pkg::IN_DEPTH)
  ) u_in_fifo (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst   (i_sys_rst),
    .i_push      (i_beat_valid),
    .i_push_data (i_beat),
    .i_pop       (fwd),
    .o_pop_data  (head),
    .o_empty     (in_empty),
    .o_full      ()
  );

  assign fwd        = !in_empty && (eng_cnt[target] != '0);
  assign o_eng_beat = head;   // Shared bus, valid selects the engine

  always_comb begin
    o_eng_valid         = '0;
    o_eng_valid[target] = fwd;
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      o_beat_credit <= 1'b0;
      target        <= '0;
      for (int k = 0; k < N; k++) begin
        eng_cnt[k] <= CW'(crc_cfg_pkg::ENG_BYTE_DEPTH);  // Engines start empty
      end
    end else begin
      o_beat_credit <= fwd;   // Freed slot goes back upstream next cycle
      if (fwd && head.last) begin
        target <= (target == SW'(N - 1)) ? '0 : target + 1'b1;
      end
      for (int k = 0; k < N; k++) begin
        if (i_eng_credit[k] && !o_eng_valid[k]) begin
          eng_cnt[k] <= eng_cnt[k] + 1'b1;
        end else if (!i_eng_credit[k] && o_eng_valid[k]) begin
          eng_cnt[k] <= eng_cnt[k] - 1'b1;
        end
      end
    end
  end

  // Engine credit returns must balance the bytes sent to it
  for (genvar k = 0; k < N; k++) begin : g_chk
    a_eng_credit: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
      (eng_cnt[k] <= CW'(crc_cfg_pkg::ENG_BYTE_DEPTH)) &&
      (o_eng_valid[k] -> (eng_cnt[k] != '0)))
      else $error("frame_dispatcher: engine %0d credit out of range", k);
  end

endmodule

`default_nettype wire

// File: credit_fifo.sv
// ------------------------------
// Small circular FIFO
// Show-ahead head, any packed payload
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module credit_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 2
) (
  input  wire           i_sys_clk,
  input  wire           i_sys_rst,
  input  wire           i_push,
  input  wire payload_t i_push_data,
  input  wire           i_pop,
  output payload_t      o_pop_data,
  output logic          o_empty,
  output logic          o_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // Depth 1 still needs a bit
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;    // Occupancy
  logic             do_push;
  logic             do_pop;

  assign o_empty    = (count == '0);
  assign o_full     = (count == CNT_W'(DEPTH));
  assign do_pop     = i_pop && !o_empty;
  assign do_push    = i_push && (!o_full || do_pop);  // Slot freed in the same cycle
  assign o_pop_data = mem[rd_ptr];                      // Head visible before the pop

  always_ff @(posedge i_sys_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= i_push_data;
    end
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap at depth
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;       // Both or neither
      endcase
    end
  end

  // Credit discipline of the producer and consumer keeps these quiet
  a_no_overflow: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    i_push |-> (!o_full || i_pop))
    else $error("credit_fifo: push while full");

  a_no_underflow: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    i_pop |-> !o_empty)
    else $error("credit_fifo: pop while empty");

endmodule

`default_nettype wire

// File: crc_types_pkg.sv
// ------------------------------
// CRC-5 payload types
// Frame beat and per-frame CRC result
// ------------------------------
`default_nettype none

package crc_types_pkg;

  // One byte of a frame, 9 bits
  typedef struct packed {
    logic [7:0] data;   // Byte value, sent MSB first into the CRC
    logic       last;   // Closes the frame
  } beat_t;

  // One frame's outcome, 13 bits
  typedef struct packed {
    logic [crc_cfg_pkg::CRC_WIDTH-1:0] crc;   // Register after the last bit
    logic [crc_cfg_pkg::LEN_WIDTH-1:0] len;   // Bytes in the frame
  } crc_result_t;

endpackage

`default_nettype wire

// File: crc_cfg_pkg.sv
// ------------------------------
// CRC-5 configuration constants
// CRC shape, engine count and credit depths
// ------------------------------
`default_nettype none

package crc_cfg_pkg;

  // Generator x^5 + x^2 + 1
  localparam int CRC_WIDTH = 5;
  localparam logic [CRC_WIDTH-1:0] CRC_POLY = 5'b00101;  // Low bits of the generator
  localparam logic [CRC_WIDTH-1:0] CRC_INIT = 5'b11111;  // Preset at each frame start

  localparam int NUM_ENGINES   = 4;                      // Parallel bit-serial engines
  localparam int ENG_SEL_WIDTH = $clog2(NUM_ENGINES);   // Round-robin pointer width

  // Byte slots per engine, equal to the dispatcher's starting credits
  localparam int ENG_BYTE_DEPTH = 2;
  localparam int ENG_CNT_WIDTH  = $clog2(ENG_BYTE_DEPTH + 1);

  localparam int IN_DEPTH  = 4;            // Input buffer, upstream starting credits
  localparam int LEN_WIDTH = 8;            // Frame length, 1 to 255 bytes

  // Downstream credits may pile up while results are scarce
  localparam int RES_CREDIT_WIDTH = 16;

endpackage

`default_nettype wire
